// File: mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Data and address width
`define MEM_XLEN 32

// Data memory size in words, address wraps at this depth
`define MEM_DEPTH_WORDS 256

// Upper bound of extra wait cycles in the data memory
`define MEM_MAX_WAIT 3

`endif

// File: mem_pkg.sv
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  typedef struct packed {
    logic valid;
    logic wren;
    logic load;
    logic store;
    logic fence;
  } op_flags_t;

  // One operation handed over by an execute lane
  typedef struct packed {
    op_flags_t flags;
    logic [4:0] waddr;
    logic [`MEM_XLEN-1:0] result;   // ALU value
    logic [`MEM_XLEN-1:0] address;
    logic [`MEM_XLEN-1:0] sdata;
    mem_size_e size;
    logic unsigned_load;
  } lane_op_t;

  typedef struct packed {
    logic valid;
    logic [`MEM_XLEN-1:0] addr;
    logic [`MEM_XLEN-1:0] wdata;
    logic [`MEM_XLEN/8-1:0] wstrb;   // All zero for a read
  } dmem_req_t;

  typedef struct packed {
    logic ready;
    logic [`MEM_XLEN-1:0] rdata;
  } dmem_rsp_t;

  typedef struct packed {
    logic wren;
    logic [4:0] waddr;
    logic [`MEM_XLEN-1:0] wdata;
  } fwd_t;

  typedef struct packed {
    logic valid;
    fwd_t lane0;
    fwd_t lane1;
  } wb_t;

  localparam lane_op_t init_lane_op = '0;
  localparam wb_t init_wb = '0;

endpackage

`default_nettype wire

// File: load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
  input mem_pkg::lane_op_t op,
  input logic [31:0] rdata,
  output logic [31:0] ldata,
  output logic [31:0] wdata,
  output logic [3:0] wstrb
);
  import mem_pkg::*;

  logic [1:0] offset;
  logic [7:0] byte_sel;
  logic [15:0] half_sel;
  logic [3:0] strb;

  always_comb begin
    offset = op.address[1:0];
    byte_sel = rdata[{offset, 3'b000} +: 8];
    half_sel = offset[1] ? rdata[31:16] : rdata[15:0];
    case (op.size)
      SIZE_BYTE: ldata = {{24{byte_sel[7] & ~op.unsigned_load}}, byte_sel};
      SIZE_HALF: ldata = {{16{half_sel[15] & ~op.unsigned_load}}, half_sel};
      default: ldata = rdata;
    endcase
  end

  // Store data goes out on every byte lane, strobe picks the ones written
  always_comb begin
    case (op.size)
      SIZE_BYTE: begin
        wdata = {4{op.sdata[7:0]}};
        strb = 4'b0001 << offset;
      end
      SIZE_HALF: begin
        wdata = {2{op.sdata[15:0]}};
        strb = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wdata = op.sdata;
        strb = 4'b1111;
      end
    endcase
    wstrb = op.flags.store ? strb : 4'b0000;   // Loads and fences read
  end

endmodule

`default_nettype wire

// File: dtim.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module dtim (
  input logic clock,
  input logic reset,
  input mem_pkg::dmem_req_t req,
  output mem_pkg::dmem_rsp_t rsp
);
  import mem_pkg::*;

  localparam int AW = $clog2(`MEM_DEPTH_WORDS);
  localparam int CW = $clog2(`MEM_MAX_WAIT + 1);

  logic [`MEM_XLEN-1:0] mem [`MEM_DEPTH_WORDS];
  dmem_req_t req_q;
  logic busy_q;
  logic [CW-1:0] count_q;
  logic [15:0] lfsr_q;
  logic [AW-1:0] index;
  logic done;

  always_comb begin
    index = req_q.addr[AW+1:2];   // Word index, wraps at the depth
    done = busy_q & (count_q == '0);
    rsp.ready = done;
    rsp.rdata = mem[index];
  end

  // Idle/busy control, wait length drawn from the LFSR on capture
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      busy_q <= 1'b0;
      count_q <= '0;
      lfsr_q <= 16'hace1;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      if (!busy_q) begin
        if (req.valid) begin
          busy_q <= 1'b1;
          count_q <= CW'(lfsr_q % 16'(`MEM_MAX_WAIT + 1));
        end
      end else if (done) begin
        busy_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!busy_q && req.valid) begin
      req_q <= req;
    end
  end

  always_ff @(posedge clock) begin
    if (done) begin
      for (int i = 0; i < `MEM_XLEN / 8; i++) begin
        if (req_q.wstrb[i]) begin
          mem[index][8*i +: 8] <= req_q.wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
  input logic clock,
  input logic reset,
  input mem_pkg::lane_op_t ex_lane0,
  input mem_pkg::lane_op_t ex_lane1,
  input logic clear,
  output logic stall,
  output mem_pkg::dmem_req_t dmem_req,
  input mem_pkg::dmem_rsp_t dmem_rsp,
  input logic [31:0] ldata0,
  input logic [31:0] ldata1,
  input logic [31:0] wdata0,
  input logic [31:0] wdata1,
  input logic [3:0] wstrb0,
  input logic [3:0] wstrb1,
  output mem_pkg::lane_op_t lane0_q,
  output mem_pkg::lane_op_t lane1_q,
  output mem_pkg::fwd_t fwd0,
  output mem_pkg::fwd_t fwd1,
  output mem_pkg::wb_t wb
);
  import mem_pkg::*;

  logic orphan_q;   // Memory still owes a response to a cleared access
  logic mem0, mem1, own1, owner_mem, both_mem, own_ready;
  logic [31:0] wval0, wval1;

  function automatic logic is_mem(input lane_op_t op);
    return op.flags.valid & (op.flags.load | op.flags.store | op.flags.fence);
  endfunction

  always_comb begin
    mem0 = is_mem(lane0_q);
    mem1 = is_mem(lane1_q);
    own1 = ~mem0 & mem1;   // Lane 0 first
    owner_mem = mem0 | mem1;
    both_mem = mem0 & mem1;
    own_ready = dmem_rsp.ready & ~orphan_q;
    // With two accesses the first ready only finishes lane 0
    stall = owner_mem & (~own_ready | both_mem) & ~clear;
    wval0 = lane0_q.flags.load ? ldata0 : lane0_q.result;
    wval1 = lane1_q.flags.load ? ldata1 : lane1_q.result;
  end

  always_comb begin
    dmem_req.valid = owner_mem & ~orphan_q;
    dmem_req.addr = own1 ? lane1_q.address : lane0_q.address;
    dmem_req.wdata = own1 ? wdata1 : wdata0;
    dmem_req.wstrb = own1 ? wstrb1 : wstrb0;
  end

  always_comb begin
    fwd0.wren = lane0_q.flags.valid & lane0_q.flags.wren;
    fwd0.waddr = lane0_q.waddr;
    fwd0.wdata = wval0;
    fwd1.wren = lane1_q.flags.valid & lane1_q.flags.wren;
    fwd1.waddr = lane1_q.waddr;
    fwd1.wdata = wval1;
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      lane0_q <= init_lane_op;
      lane1_q <= init_lane_op;
      wb <= init_wb;
      orphan_q <= 1'b0;
    end else begin
      if (dmem_rsp.ready) begin
        orphan_q <= 1'b0;
      end else if (clear && dmem_req.valid) begin
        orphan_q <= 1'b1;   // Access already captured, its ready must be dropped
      end
      if (clear) begin
        lane0_q <= init_lane_op;
        lane1_q <= init_lane_op;
        wb <= init_wb;
      end else if (stall) begin
        wb <= init_wb;
        if (own_ready) begin
          // Lane 0 done, keep its value and hand the port to lane 1
          lane0_q.result <= wval0;
          lane0_q.flags.load <= 1'b0;
          lane0_q.flags.store <= 1'b0;
          lane0_q.flags.fence <= 1'b0;
        end
      end else begin
        wb.valid <= lane0_q.flags.valid | lane1_q.flags.valid;
        wb.lane0 <= fwd0;
        wb.lane1 <= fwd1;
        lane0_q <= ex_lane0;
        if (ex_lane0.flags.valid && ex_lane0.flags.fence) begin
          lane1_q <= init_lane_op;   // Nothing issues beside a fence
        end else begin
          lane1_q <= ex_lane1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input logic clock,
  input logic reset,
  input mem_pkg::lane_op_t ex_lane0,
  input mem_pkg::lane_op_t ex_lane1,
  input logic clear,
  output logic stall,
  output mem_pkg::fwd_t fwd0,
  output mem_pkg::fwd_t fwd1,
  output mem_pkg::wb_t wb
);
  import mem_pkg::*;

  dmem_req_t dmem_req;
  dmem_rsp_t dmem_rsp;
  lane_op_t lane0_q, lane1_q;
  logic [31:0] ldata0, ldata1;
  logic [31:0] wdata0, wdata1;
  logic [3:0] wstrb0, wstrb1;

  memory_stage u_memory_stage (
    .clock(clock), .reset(reset),
    .ex_lane0(ex_lane0), .ex_lane1(ex_lane1),
    .clear(clear), .stall(stall),
    .dmem_req(dmem_req), .dmem_rsp(dmem_rsp),
    .ldata0(ldata0), .ldata1(ldata1),
    .wdata0(wdata0), .wdata1(wdata1),
    .wstrb0(wstrb0), .wstrb1(wstrb1),
    .lane0_q(lane0_q), .lane1_q(lane1_q),
    .fwd0(fwd0), .fwd1(fwd1), .wb(wb)
  );

  load_align u_align0 (.op(lane0_q), .rdata(dmem_rsp.rdata), .ldata(ldata0),
    .wdata(wdata0), .wstrb(wstrb0));
  load_align u_align1 (.op(lane1_q), .rdata(dmem_rsp.rdata), .ldata(ldata1),
    .wdata(wdata1), .wstrb(wstrb1));

  dtim u_dtim (.clock(clock), .reset(reset), .req(dmem_req), .rsp(dmem_rsp));

endmodule

`default_nettype wire

// File: mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic stall,
  input mem_pkg::dmem_req_t dmem_req,
  input mem_pkg::dmem_rsp_t dmem_rsp
);
  import mem_pkg::*;

  int fail_count = 0;
  logic outstanding_q;   // Memory holds a captured access

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      outstanding_q <= 1'b0;
    end else if (dmem_rsp.ready) begin
      outstanding_q <= 1'b0;
    end else if (dmem_req.valid) begin
      outstanding_q <= 1'b1;
    end
  end

  stall_after_reset: assert property (@(posedge clock) !reset |=> !stall)
    else begin
      $error("stall high right after reset");
      fail_count++;
    end

  req_held: assert property (@(posedge clock) disable iff (!reset)
    (dmem_req.valid && !dmem_rsp.ready && !clear) |=> dmem_req.valid)
    else begin
      $error("request dropped before ready");
      fail_count++;
    end

  ready_pending: assert property (@(posedge clock) disable iff (!reset)
    dmem_rsp.ready |-> outstanding_q)
    else begin
      $error("ready without a pending access");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: tb_mem_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_monitor (
  input logic clock,
  input logic reset,
  input mem_pkg::lane_op_t ex_lane0,
  input mem_pkg::lane_op_t ex_lane1,
  input logic clear,
  input logic stall,
  input mem_pkg::fwd_t fwd0,
  input mem_pkg::fwd_t fwd1,
  input mem_pkg::wb_t wb,
  output int error_count,
  output int pending_count
);
  import mem_pkg::*;

  logic [31:0] model_mem [256];
  wb_t exp_q [$];
  lane_op_t held0, held1;
  logic held_valid;
  logic stall_d;

  function automatic logic [31:0] load_value(input lane_op_t op);
    logic [31:0] word;
    logic [1:0] off;
    logic [7:0] b;
    logic [15:0] h;
    word = model_mem[op.address[9:2]];
    off = op.address[1:0];
    b = word[off*8 +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    if (op.size == SIZE_BYTE) return op.unsigned_load ? {24'b0, b} : {{24{b[7]}}, b};
    if (op.size == SIZE_HALF) return op.unsigned_load ? {16'b0, h} : {{16{h[15]}}, h};
    return word;
  endfunction

  function automatic void apply_store(input lane_op_t op);
    logic [7:0] idx;
    logic [1:0] off;
    idx = op.address[9:2];
    off = op.address[1:0];
    if (op.size == SIZE_BYTE) model_mem[idx][off*8 +: 8] = op.sdata[7:0];
    else if (op.size == SIZE_HALF && off[1]) model_mem[idx][31:16] = op.sdata[15:0];
    else if (op.size == SIZE_HALF) model_mem[idx][15:0] = op.sdata[15:0];
    else model_mem[idx] = op.sdata;
  endfunction

  function automatic fwd_t lane_record(input lane_op_t op);
    fwd_t r;
    r.wren = op.flags.valid & op.flags.wren;
    r.waddr = op.waddr;
    r.wdata = (op.flags.valid && op.flags.load) ? load_value(op) : op.result;
    return r;
  endfunction

  // Reference model, lane 0 reaches memory before lane 1
  function automatic wb_t expected_wb(input lane_op_t op0, input lane_op_t op1);
    wb_t r;
    r.valid = op0.flags.valid | op1.flags.valid;
    r.lane0 = lane_record(op0);
    if (op0.flags.valid && op0.flags.store) apply_store(op0);
    r.lane1 = lane_record(op1);
    if (op1.flags.valid && op1.flags.store) apply_store(op1);
    return r;
  endfunction

  function automatic logic has_mem(input lane_op_t op);
    return op.flags.valid & (op.flags.load | op.flags.store | op.flags.fence);
  endfunction

  initial begin
    error_count = 0;
    pending_count = 0;
    held_valid = 1'b0;
    stall_d = 1'b0;
  end

  always @(posedge clock) begin
    wb_t exp;
    if (reset == 0) begin
      held_valid = 1'b0;
      stall_d = 1'b0;
    end else begin
      if (wb.valid) begin
        if (stall && stall_d) begin
          $display("error at %0t: wb valid during stall", $time);
          error_count++;
        end
        if (exp_q.size() == 0) begin
          $display("error at %0t: unexpected wb record %h", $time, wb);
          error_count++;
        end else begin
          exp = exp_q.pop_front();
          if (wb !== exp) begin
            $display("error at %0t: wb %h, expected %h", $time, wb, exp);
            error_count++;
          end
        end
      end
      if (clear) begin
        // A captured store still lands in memory
        if (held_valid && has_mem(held0) && held0.flags.store) apply_store(held0);
        else if (held_valid && !has_mem(held0) && has_mem(held1) && held1.flags.store)
          apply_store(held1);
        held_valid = 1'b0;
      end else if (!stall) begin
        if (held_valid) begin
          exp = expected_wb(held0, held1);
          // Forwarding shows the finished pair in the cycle it leaves the stage
          if (fwd0 !== exp.lane0 || fwd1 !== exp.lane1) begin
            $display("error at %0t: fwd %h %h, expected %h %h", $time, fwd0, fwd1,
                     exp.lane0, exp.lane1);
            error_count++;
          end
          if (exp.valid) exp_q.push_back(exp);
        end
        held0 = ex_lane0;
        held1 = (ex_lane0.flags.valid && ex_lane0.flags.fence) ? init_lane_op : ex_lane1;
        held_valid = held0.flags.valid | held1.flags.valid;
      end
      stall_d = stall;
    end
    pending_count = exp_q.size() + (held_valid ? 1 : 0);
  end

endmodule

`default_nettype wire

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
  import mem_pkg::*;

  logic clock;
  logic reset;
  logic clear;
  logic stall;
  lane_op_t ex_lane0, ex_lane1;
  fwd_t fwd0, fwd1;
  wb_t wb;
  int error_count, pending_count, assert_count;
  int seed = 32'h8913;
  logic timed_out;

  mem_subsystem u_mem_subsystem (
    .clock(clock), .reset(reset),
    .ex_lane0(ex_lane0), .ex_lane1(ex_lane1),
    .clear(clear), .stall(stall),
    .fwd0(fwd0), .fwd1(fwd1), .wb(wb)
  );

  bind memory_stage mem_checker u_mem_checker (.clock(clock), .reset(reset),
    .clear(clear), .stall(stall), .dmem_req(dmem_req), .dmem_rsp(dmem_rsp));

  tb_mem_monitor u_monitor (
    .clock(clock), .reset(reset),
    .ex_lane0(ex_lane0), .ex_lane1(ex_lane1),
    .clear(clear), .stall(stall),
    .fwd0(fwd0), .fwd1(fwd1), .wb(wb),
    .error_count(error_count), .pending_count(pending_count)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic lane_op_t alu_op(input logic [4:0] waddr, input logic [31:0] value);
    lane_op_t op;
    op = init_lane_op;
    op.flags.valid = 1'b1;
    op.flags.wren = 1'b1;
    op.waddr = waddr;
    op.result = value;
    return op;
  endfunction

  function automatic lane_op_t load_op(input logic [4:0] waddr, input logic [31:0] addr,
                                       input mem_size_e size, input logic uns);
    lane_op_t op;
    op = alu_op(waddr, 32'h0);
    op.flags.load = 1'b1;
    op.address = addr;
    op.size = size;
    op.unsigned_load = uns;
    return op;
  endfunction

  function automatic lane_op_t store_op(input logic [31:0] addr, input logic [31:0] data,
                                        input mem_size_e size);
    lane_op_t op;
    op = init_lane_op;
    op.flags.valid = 1'b1;
    op.flags.store = 1'b1;
    op.address = addr;
    op.sdata = data;
    op.size = size;
    return op;
  endfunction

  function automatic lane_op_t fence_op();
    lane_op_t op;
    op = init_lane_op;
    op.flags.valid = 1'b1;
    op.flags.fence = 1'b1;
    return op;
  endfunction

  task automatic report_timeout(input string what);
    if (!timed_out) begin
      $display("Timeout: %s", what);
    end
    timed_out = 1'b1;
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send_pair(input lane_op_t op0, input lane_op_t op1);
    int waited;
    waited = 0;
    ex_lane0 = op0;
    ex_lane1 = op1;
    while (stall && !timed_out && waited < 50) begin
      @(negedge clock);
      waited++;
    end
    if (stall) begin
      report_timeout("stall never dropped");
    end else begin
      @(negedge clock);
      ex_lane0 = init_lane_op;
      ex_lane1 = init_lane_op;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (stall && !timed_out && waited < 50) begin
      @(negedge clock);
      waited++;
    end
    if (stall) begin
      report_timeout("stall never dropped while draining");
    end else begin
      repeat (3) @(negedge clock);
    end
  endtask

  task automatic pulse_clear();
    clear = 1'b1;
    @(negedge clock);
    clear = 1'b0;
    repeat (8) @(negedge clock);   // Lets the orphaned response pass
  endtask

  task automatic random_lane(input logic lane0, output lane_op_t op);
    int kind, word, sz, off;
    kind = $unsigned($random(seed)) % 8;
    word = $unsigned($random(seed)) % 32;
    sz = $unsigned($random(seed)) % 3;
    off = (sz == 2) ? 0 : (sz == 1) ? 2 * ($unsigned($random(seed)) % 2)
                                     : $unsigned($random(seed)) % 4;
    if (kind < 3 || (kind == 7 && !lane0)) op = alu_op(5'($random(seed)), $random(seed));
    else if (kind < 5) op = load_op(5'($random(seed)), word * 4 + off, mem_size_e'(sz),
                                    kind[0]);
    else if (kind < 7) op = store_op(word * 4 + off, $random(seed), mem_size_e'(sz));
    else op = fence_op();
  endtask

  initial begin
    lane_op_t r0, r1;
    reset = 1'b0;
    clear = 1'b0;
    timed_out = 1'b0;
    ex_lane0 = init_lane_op;
    ex_lane1 = init_lane_op;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    @(negedge clock);
    for (int i = 0; i < 256; i++)   // Fill pattern from the whole word index
      send_pair(store_op(i * 4, {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3 + i[7:0]},
                         SIZE_WORD), init_lane_op);
    send_pair(store_op(32'h40, 32'hdeadbeef, SIZE_WORD), load_op(5'd3, 32'h40, SIZE_WORD, 0));
    send_pair(alu_op(5'd1, 32'h11), store_op(32'h44, 32'h12345678, SIZE_WORD));
    send_pair(load_op(5'd4, 32'h44, SIZE_WORD, 0), alu_op(5'd2, 32'h22));
    for (int off = 0; off < 4; off++) begin
      send_pair(store_op(32'h80 + off, 32'h80 | off, SIZE_BYTE), init_lane_op);
      send_pair(load_op(5'd5, 32'h80 + off, SIZE_BYTE, 0),
                load_op(5'd6, 32'h80 + off, SIZE_BYTE, 1));
    end
    for (int off = 0; off < 4; off += 2) begin
      send_pair(store_op(32'h84 + off, 32'h8001 + off, SIZE_HALF), init_lane_op);
      send_pair(load_op(5'd7, 32'h84 + off, SIZE_HALF, 0),
                load_op(5'd8, 32'h84 + off, SIZE_HALF, 1));
      send_pair(load_op(5'd9, 32'h84, SIZE_WORD, 0), load_op(5'd10, 32'h85, SIZE_BYTE, 0));
    end
    for (int i = 0; i < 6; i++)
      send_pair(alu_op(5'(i), 32'h1000 + i), alu_op(5'(i + 8), 32'h2000 + i));
    send_pair(alu_op(5'd11, 32'h33), load_op(5'd12, 32'h40, SIZE_WORD, 0));
    send_pair(fence_op(), alu_op(5'd13, 32'h44));
    send_pair(alu_op(5'd14, 32'h55), alu_op(5'd15, 32'h66));
    drain();
    send_pair(store_op(32'h90, 32'hcafef00d, SIZE_WORD), alu_op(5'd16, 32'h77));
    pulse_clear();
    send_pair(alu_op(5'd17, 32'h88), alu_op(5'd18, 32'h99));
    pulse_clear();
    send_pair(load_op(5'd19, 32'h90, SIZE_WORD, 0), init_lane_op);
    for (int i = 0; i < 200; i++) begin
      random_lane(1'b1, r0);
      random_lane(1'b0, r1);
      send_pair(r0, r1);
    end
    drain();
    assert_count = u_mem_subsystem.u_memory_stage.u_mem_checker.fail_count;
    if (pending_count != 0) begin
      $display("Records missing on wb: %0d", pending_count);
    end
    $display("Errors: compare %0d, assertion %0d, missing %0d", error_count, assert_count,
             pending_count);
    if (!timed_out && error_count == 0 && assert_count == 0 && pending_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
mem_pkg.sv
load_align.sv
dtim.sv
memory_stage.sv
mem_subsystem.sv
mem_checker.sv
tb_mem_monitor.sv
tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - load_align.sv
      - dtim.sv
      - memory_stage.sv
      - mem_subsystem.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - mem_checker.sv
      - tb_mem_monitor.sv
      - tb_mem_subsystem.sv
